// ==== bench/led_subsystem_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_subsystem_checker
    import led_pkg::*;
(
    input  wire         sysclk,
    input  wire         rst,
    input  wire         led_ticks_t ticks,
    input  wire         led_drive_t leds,
    input  wire         flash_active
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Reset leaves every LED dark on the next edge
    assert property (@(posedge sysclk) rst |=> (leds == '0))
        else begin
            fail_count++;
            $error("LED outputs not cleared after reset");
        end

    // Power-up flash drives reds only
    assert property (@(posedge sysclk) disable iff (rst)
        flash_active |=> (!leds.led1_grn && !leds.led2_grn))
        else begin
            fail_count++;
            $error("green LED lit during power-up flash");
        end

    // Strobes are single-cycle pulses
    assert property (@(posedge sysclk) disable iff (rst) ticks.blink |=> !ticks.blink)
        else begin
            fail_count++;
            $error("blink strobe high for two cycles");
        end

    assert property (@(posedge sysclk) disable iff (rst) ticks.frame |=> !ticks.frame)
        else begin
            fail_count++;
            $error("frame strobe high for two cycles");
        end

    assert property (@(posedge sysclk) disable iff (rst) ticks.ramp |=> !ticks.ramp)
        else begin
            fail_count++;
            $error("ramp strobe high for two cycles");
        end

endmodule

`default_nettype wire

// ==== bench/led_subsystem_input.txt ====
# period(hex) timeout display_enable expected_mode
# mode 0 disable, 1 to 5 phase one to five, 6 timeout
0001 0 1 1
2580 0 1 1
2581 0 1 2
4B00 0 1 2
4B01 0 1 3
7080 0 1 3
7081 0 1 4
9600 0 1 4
9601 0 1 5
FFFF 0 1 5
0000 0 1 0
1234 1 1 6
0000 1 1 6
FFFF 1 1 6
3000 0 0 2
8000 1 0 6
5000 0 1 3
0000 0 0 0

// ==== bench/led_subsystem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_settings.svh"

module led_subsystem_tb
    import led_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int FRAME        = `LED_PWM_FRAME;
    localparam int FLASH_CYCLES = `LED_FLASH_COUNT * `LED_BLINK_DIV;
    // First whole PWM frame once the flash is over
    localparam int PWM_START    = ((FLASH_CYCLES + FRAME - 1) / FRAME) * FRAME;
    localparam int RAMP_CYCLES  = FRAME * `LED_RAMP_DIV;
    // Blink counter steps every 6 blink strobes
    localparam int BITS_CYCLES  = 6 * `LED_BLINK_DIV;
    localparam logic [31:0] SEED = 32'h08bde352;

    // One line of the stimulus file
    typedef struct packed {
        logic [15:0] period;
        logic        timeout;
        logic        enable;
        wdog_mode_e  mode;
    } vec_t;

    logic        sysclk = 1'b0;
    logic        rst;
    logic [15:0] wdog_period;
    logic        wdog_timeout;
    logic        wdog_period_led;
    led_drive_t  leds;

    int   n;
    int   checks;
    int   errors;
    int   hi[4];
    logic led1_dirty;
    logic loaded;
    int   timeout_ns;
    vec_t vecs[$];

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    led_subsystem_top led_subsystem_top_i (
        .sysclk          (sysclk),
        .rst             (rst),
        .wdog_period     (wdog_period),
        .wdog_timeout    (wdog_timeout),
        .wdog_period_led (wdog_period_led),
        .leds            (leds)
    );

    bind ctrl_led led_subsystem_checker checker_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .ticks        (ticks),
        .leds         (leds),
        .flash_active (flash_active)
    );

    task automatic check_drive(input led_drive_t got, input led_drive_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s leds %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_duty(input logic [6:0] got, input logic [6:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s %0d high cycles expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - mark);
        end
    endtask

    // Advance one cycle and sample leds mid-cycle
    // sample n shows the PWM state of cycle n - 1
    task automatic step_cycle();
        int c;
        int ramp_no;
        @(negedge sysclk);
        n++;
        c = n - 1;
        if (c >= PWM_START) begin
            hi[0] += int'(leds.led1_grn);
            hi[1] += int'(leds.led1_red);
            hi[2] += int'(leds.led2_grn);
            hi[3] += int'(leds.led2_red);
            // LED1 only counts for frames with the display off throughout
            if (wdog_period_led) begin
                led1_dirty = 1'b1;
            end
            if ((c % FRAME) == FRAME - 1) begin
                ramp_no = c / RAMP_CYCLES;
                // Start phases 8, 22, 0 and 6
                if (!led1_dirty) begin
                    check_duty(7'(hi[0]), led_profile(5'(8 + ramp_no)), "led1_grn duty");
                    check_duty(7'(hi[1]), led_profile(5'(22 + ramp_no)), "led1_red duty");
                end
                check_duty(7'(hi[2]), led_profile(5'(0 + ramp_no)), "led2_grn duty");
                check_duty(7'(hi[3]), led_profile(5'(6 + ramp_no)), "led2_red duty");
                foreach (hi[k]) begin
                    hi[k] = 0;
                end
                led1_dirty = 1'b0;
            end
        end
    endtask

    // Apply one vector and hold it
    // LED1 is checked from the second sample on
    task automatic run_line(input vec_t v, input int hold);
        logic [2:0] bb;
        logic       exp_g;
        logic       exp_r;
        wdog_period     = v.period;
        wdog_timeout    = v.timeout;
        wdog_period_led = v.enable;
        for (int i = 0; i < hold; i++) begin
            step_cycle();
            if (v.enable && i >= 1) begin
                bb    = 3'((n - 1) / BITS_CYCLES);
                exp_g = 1'b0;
                exp_r = 1'b0;
                case (v.mode)
                    WDOG_PHASE_ONE:   exp_g = 1'b1;
                    WDOG_PHASE_TWO:   exp_g = bb[0];
                    WDOG_PHASE_THREE: exp_g = bb[1];
                    WDOG_PHASE_FOUR:  exp_g = bb[2];
                    WDOG_DISABLE:     exp_r = bb[0];
                    WDOG_TIMEOUT:     exp_r = 1'b1;
                    default: ;
                endcase
                check_bit(leds.led1_grn, exp_g, "led1_grn");
                check_bit(leds.led1_red, exp_r, "led1_red");
            end
        end
    endtask

    // Run limit scales with the number of vectors
    initial begin
        wait (loaded === 1'b1);
        #(timeout_ns);
        $display("simulation timed out at %0t before all tests finished", $time);
        $display("test failed");
        $finish;
    end

    initial begin
        vec_t  v;
        int    fd;
        string line;
        int    p, t, e, m;
        int    mark;
        int    hold;
        int    afails;
        logic  sig;
        rst             = 1'b1;
        wdog_period     = 16'h0000;
        wdog_timeout    = 1'b0;
        wdog_period_led = 1'b0;
        n               = 0;
        checks          = 0;
        errors          = 0;
        led1_dirty      = 1'b0;
        loaded          = 1'b0;
        foreach (hi[k]) begin
            hi[k] = 0;
        end
        void'($urandom(SEED));

        fd = $fopen("bench/led_subsystem_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open bench/led_subsystem_input.txt");
        end else begin
            // Lines starting with # are column notes
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %d %d %d", p, t, e, m) == 4) begin
                        v.period  = 16'(p);
                        v.timeout = 1'(t);
                        v.enable  = 1'(e);
                        v.mode    = wdog_mode_e'(m);
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
        timeout_ns = (vecs.size() + 4) * 40 * `LED_BLINK_DIV * CLK_PERIOD;
        loaded = 1'b1;

        repeat (4) @(negedge sysclk);
        rst = 1'b0;

        // Power-up flash with both reds toggling each blink period
        mark = errors;
        repeat (FLASH_CYCLES) begin
            step_cycle();
            sig = 1'(((n - 1) / `LED_BLINK_DIV) % 2);
            check_drive(leds, led_drive_t'({1'b0, sig, 1'b0, sig}), "flash");
        end
        report_test("flash", mark);

        // Four whole frames of the breathing pattern
        mark = errors;
        while (n < PWM_START + 4 * FRAME) begin
            step_cycle();
        end
        report_test("pwm", mark);

        foreach (vecs[k]) begin
            mark = errors;
            hold = (12 + $urandom % 25) * `LED_BLINK_DIV;
            run_line(vecs[k], hold);
            report_test($sformatf("line %0d mode %0d", k, vecs[k].mode), mark);
        end

        // Display on for two frames and then LED1 falls back to PWM
        mark = errors;
        v.period  = 16'h0001;
        v.timeout = 1'b0;
        v.enable  = 1'b1;
        v.mode    = WDOG_PHASE_ONE;
        run_line(v, 2 * FRAME);
        wdog_period_led = 1'b0;
        repeat (4 * FRAME) step_cycle();
        report_test("release", mark);

        afails = led_subsystem_top_i.ctrl_led_i.checker_i.fail_count;
        $display("%0d checks, %0d mismatches, %0d assertion failures", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/led_pkg.sv
src/wdog_period_classifier.sv
src/led_tick_gen.sv
src/led_pwm_channel.sv
src/ctrl_led.sv
src/led_subsystem_top.sv
bench/led_subsystem_checker.sv
bench/led_subsystem_tb.sv

// ==== src/ctrl_led.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_settings.svh"

module ctrl_led
    import led_pkg::*;
(
    input  wire         sysclk,
    input  wire         rst,
    input  wire         wdog_mode_e mode,
    input  wire         wdog_period_led,
    input  wire         led_ticks_t ticks,
    input  wire         led_drive_t pwm_leds,
    output led_drive_t  leds
);

    localparam int FLASH_W = $clog2(`LED_FLASH_COUNT + 1);

    logic [FLASH_W-1:0] flash_cnt;
    logic               flash_active;
    logic               flash_sig;
    logic [2:0]         blink_div;
    logic [2:0]         blink_bits;
    logic               wdog_grn;
    logic               wdog_red;
    led_drive_t         leds_next;

    // Power-up flash runs until the blink count is used up
    assign flash_active = (flash_cnt != FLASH_W'(`LED_FLASH_COUNT));

    always_ff @(posedge sysclk) begin
        if (rst) begin
            flash_cnt <= '0;
            flash_sig <= 1'b0;
        end else if (ticks.blink && flash_active) begin
            flash_cnt <= flash_cnt + 1'b1;
            // Reds toggle once per blink strobe
            flash_sig <= ~flash_sig;
        end
    end

    // Divide blink strobes by 6, then count
    // bit 0 fast, bit 1 medium, bit 2 slow
    always_ff @(posedge sysclk) begin
        if (rst) begin
            blink_div  <= 3'd0;
            blink_bits <= 3'd0;
        end else if (ticks.blink) begin
            if (blink_div == 3'd5) begin
                blink_div  <= 3'd0;
                blink_bits <= blink_bits + 3'd1;
            end else begin
                blink_div <= blink_div + 3'd1;
            end
        end
    end

    // Watchdog display on LED1
    always_comb begin
        wdog_grn = 1'b0;
        wdog_red = 1'b0;
        case (mode)
            WDOG_PHASE_ONE:   wdog_grn = 1'b1;
            WDOG_PHASE_TWO:   wdog_grn = blink_bits[0];
            WDOG_PHASE_THREE: wdog_grn = blink_bits[1];
            WDOG_PHASE_FOUR:  wdog_grn = blink_bits[2];
            WDOG_DISABLE:     wdog_red = blink_bits[0];
            WDOG_TIMEOUT:     wdog_red = 1'b1;
            // Phase five leaves LED1 dark
            default: ;
        endcase
    end

    // Priority: flash, then watchdog on LED1, then PWM
    always_comb begin
        if (flash_active) begin
            leds_next.led1_grn = 1'b0;
            leds_next.led1_red = flash_sig;
            leds_next.led2_grn = 1'b0;
            leds_next.led2_red = flash_sig;
        end else begin
            leds_next.led1_grn = wdog_period_led ? wdog_grn : pwm_leds.led1_grn;
            leds_next.led1_red = wdog_period_led ? wdog_red : pwm_leds.led1_red;
            leds_next.led2_grn = pwm_leds.led2_grn;
            leds_next.led2_red = pwm_leds.led2_red;
        end
    end

    // Registered LED outputs
    always_ff @(posedge sysclk) begin
        if (rst) begin
            leds <= '0;
        end else begin
            leds <= leds_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/led_pkg.sv ====
`default_nettype none

package led_pkg;

    // Watchdog display modes for LED1
    typedef enum logic [2:0] {
        WDOG_DISABLE     = 3'd0,
        WDOG_PHASE_ONE   = 3'd1,
        WDOG_PHASE_TWO   = 3'd2,
        WDOG_PHASE_THREE = 3'd3,
        WDOG_PHASE_FOUR  = 3'd4,
        WDOG_PHASE_FIVE  = 3'd5,
        WDOG_TIMEOUT     = 3'd6
    } wdog_mode_e;

    // Single-cycle strobes from the tick generator
    typedef struct packed {
        logic blink;
        logic frame;
        logic ramp;
    } led_ticks_t;

    // Board LED levels, two bicolour LEDs
    typedef struct packed {
        logic led1_grn;
        logic led1_red;
        logic led2_grn;
        logic led2_red;
    } led_drive_t;

    // Breathing profile, duty in cycles per frame, step of 8
    function automatic logic [6:0] led_profile(input logic [4:0] idx);
        logic [6:0] duty;
        duty = 7'd0;
        case (idx[4:3])
            // Long rise 8..64
            2'd0: duty = {({1'b0, idx[2:0]} + 4'd1), 3'b000};
            // Long fall 56..0
            2'd1: duty = {1'b0, (3'd7 - idx[2:0]), 3'b000};
            // Dark, then short rise 8..32
            2'd2: duty = idx[2] ? {1'b0, ({1'b0, idx[1:0]} + 3'd1), 3'b000} : 7'd0;
            // Short fall 24..0, then dark
            default: duty = idx[2] ? 7'd0 : {2'b00, (2'd3 - idx[1:0]), 3'b000};
        endcase
        return duty;
    endfunction

endpackage

`default_nettype wire

// ==== src/led_pwm_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_settings.svh"

module led_pwm_channel
    import led_pkg::*;
#(
    // Profile entry this channel starts from, 0 to 31
    parameter int unsigned start_phase = 0
) (
    input  wire         sysclk,
    input  wire         rst,
    input  wire         led_ticks_t ticks,
    output logic        pwm
);

    localparam int IDX_W = $clog2(`LED_PROFILE_LEN);
    localparam int CNT_W = $clog2(`LED_PWM_FRAME);
    // Compare width covers both the count and the 7-bit duty
    localparam int CMP_W = (CNT_W > 7) ? CNT_W : 7;

    logic [IDX_W-1:0] index;
    logic [CNT_W-1:0] count;
    logic [6:0]       duty;

    // Profile step, wraps at the end of the table
    always_ff @(posedge sysclk) begin
        if (rst) begin
            index <= IDX_W'(start_phase);
        end else if (ticks.ramp) begin
            if (index == IDX_W'(`LED_PROFILE_LEN - 1)) begin
                index <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    // Position inside the frame, restarts with the frame strobe
    always_ff @(posedge sysclk) begin
        if (rst) begin
            count <= '0;
        end else if (ticks.frame) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Duty for the current step
    assign duty = led_profile(index);

    // High for the first duty cycles of the frame
    // a duty of a full frame keeps the LED on throughout
    assign pwm = (CMP_W'(count) < CMP_W'(duty));

endmodule

`default_nettype wire

// ==== src/led_settings.svh ====
`ifndef LED_SETTINGS_SVH
`define LED_SETTINGS_SVH

// Rates are in sysclk cycles and scaled down for short runs

// sysclk cycles per blink strobe
`define LED_BLINK_DIV 8

// PWM frame length, one count per sysclk cycle
`define LED_PWM_FRAME 64

// Frames per step of the brightness profile
`define LED_RAMP_DIV 2

// Entries in the brightness profile, index is 5 bits
`define LED_PROFILE_LEN 32

// Blink strobes spent in the power-up flash
`define LED_FLASH_COUNT 15

// Watchdog period band limits, upper bound inclusive
`define WDOG_LIMIT_1 16'h2580
`define WDOG_LIMIT_2 16'h4B00
`define WDOG_LIMIT_3 16'h7080
`define WDOG_LIMIT_4 16'h9600

`endif

// ==== src/led_subsystem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_subsystem_top
    import led_pkg::*;
(
    input  wire         sysclk,
    input  wire         rst,
    input  wire  [15:0] wdog_period,
    input  wire         wdog_timeout,
    input  wire         wdog_period_led,
    output led_drive_t  leds
);

    wdog_mode_e  mode;
    led_ticks_t  ticks;
    led_drive_t  pwm_leds;
    logic        pwm_led1_grn;
    logic        pwm_led1_red;
    logic        pwm_led2_grn;
    logic        pwm_led2_red;

    // Period band and timeout to display mode
    wdog_period_classifier classifier_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .wdog_period  (wdog_period),
        .wdog_timeout (wdog_timeout),
        .mode         (mode)
    );

    // Shared blink, frame and ramp strobes
    led_tick_gen tick_gen_i (
        .sysclk (sysclk),
        .rst    (rst),
        .ticks  (ticks)
    );

    // Breathing channels, each offset along the profile
    led_pwm_channel #(.start_phase(8)) pwm_led1_grn_i (
        .sysclk (sysclk),
        .rst    (rst),
        .ticks  (ticks),
        .pwm    (pwm_led1_grn)
    );

    led_pwm_channel #(.start_phase(22)) pwm_led1_red_i (
        .sysclk (sysclk),
        .rst    (rst),
        .ticks  (ticks),
        .pwm    (pwm_led1_red)
    );

    led_pwm_channel #(.start_phase(0)) pwm_led2_grn_i (
        .sysclk (sysclk),
        .rst    (rst),
        .ticks  (ticks),
        .pwm    (pwm_led2_grn)
    );

    led_pwm_channel #(.start_phase(6)) pwm_led2_red_i (
        .sysclk (sysclk),
        .rst    (rst),
        .ticks  (ticks),
        .pwm    (pwm_led2_red)
    );

    assign pwm_leds.led1_grn = pwm_led1_grn;
    assign pwm_leds.led1_red = pwm_led1_red;
    assign pwm_leds.led2_grn = pwm_led2_grn;
    assign pwm_leds.led2_red = pwm_led2_red;

    // Output mux and power-up flash
    ctrl_led ctrl_led_i (
        .sysclk          (sysclk),
        .rst             (rst),
        .mode            (mode),
        .wdog_period_led (wdog_period_led),
        .ticks           (ticks),
        .pwm_leds        (pwm_leds),
        .leds            (leds)
    );

endmodule

`default_nettype wire

// ==== src/led_tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_settings.svh"

module led_tick_gen
    import led_pkg::*;
(
    input  wire         sysclk,
    input  wire         rst,
    output led_ticks_t  ticks
);

    localparam int BLINK_W = $clog2(`LED_BLINK_DIV + 1);
    localparam int FRAME_W = $clog2(`LED_PWM_FRAME + 1);
    localparam int RAMP_W  = $clog2(`LED_RAMP_DIV + 1);

    logic [BLINK_W-1:0] blink_cnt;
    logic [FRAME_W-1:0] frame_cnt;
    logic [RAMP_W-1:0]  ramp_cnt;
    logic               blink_end;
    logic               frame_end;
    logic               ramp_end;

    // Last cycle of each count, all zero while counters sit at reset
    assign blink_end = (blink_cnt == BLINK_W'(`LED_BLINK_DIV - 1));
    assign frame_end = (frame_cnt == FRAME_W'(`LED_PWM_FRAME - 1));
    assign ramp_end  = (ramp_cnt == RAMP_W'(`LED_RAMP_DIV - 1));

    // Strobes decoded from registered counters, one cycle wide
    assign ticks.blink = blink_end;
    assign ticks.frame = frame_end;
    assign ticks.ramp  = frame_end & ramp_end;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            blink_cnt <= '0;
            frame_cnt <= '0;
            ramp_cnt  <= '0;
        end else begin
            // Blink divider
            blink_cnt <= blink_end ? '0 : blink_cnt + 1'b1;
            // Cycle count within the PWM frame
            frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
            // Frames between profile steps
            if (frame_end) begin
                ramp_cnt <= ramp_end ? '0 : ramp_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/wdog_period_classifier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_settings.svh"

module wdog_period_classifier
    import led_pkg::*;
(
    input  wire         sysclk,
    input  wire         rst,
    input  wire  [15:0] wdog_period,
    input  wire         wdog_timeout,
    output wdog_mode_e  mode
);

    wdog_mode_e mode_next;

    // Band lookup on the period value
    always_comb begin
        if (wdog_timeout) begin
            // Timeout beats any period setting
            mode_next = WDOG_TIMEOUT;
        end else if (wdog_period == 16'h0000) begin
            mode_next = WDOG_DISABLE;
        end else if (wdog_period <= `WDOG_LIMIT_1) begin
            mode_next = WDOG_PHASE_ONE;
        end else if (wdog_period <= `WDOG_LIMIT_2) begin
            mode_next = WDOG_PHASE_TWO;
        end else if (wdog_period <= `WDOG_LIMIT_3) begin
            mode_next = WDOG_PHASE_THREE;
        end else if (wdog_period <= `WDOG_LIMIT_4) begin
            mode_next = WDOG_PHASE_FOUR;
        end else begin
            // Period beyond the last band
            mode_next = WDOG_PHASE_FIVE;
        end
    end

    // One register stage on the mode
    always_ff @(posedge sysclk) begin
        if (rst) begin
            mode <= WDOG_DISABLE;
        end else begin
            mode <= mode_next;
        end
    end

endmodule

`default_nettype wire
